//--- verilog.f
+incdir+include
source/exec_pkg.sv
source/reg_file.sv
source/inst_decoder.sv
source/exec_unit.sv
source/alu_core_top.sv
dv/alu_core_asserts.sv
dv/alu_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= alu_core_tb
RTL_TOP   ?= alu_core_top
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST) $(VFLAGS)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) $(VFLAGS)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- dv/alu_core_tb.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module alu_core_tb;

  import exec_pkg::*;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic        inst_valid = 1'b0;
  logic        inst_ready;
  inst_word_u  inst = '0;
  logic        retire_valid;
  logic        retire_ready = 1'b0;
  retire_t     retire;

  logic [15:0] lfsr_state = 16'd41;
  logic [31:0] model [32];
  logic [31:0] exp_q [$];
  logic [31:0] cap_q [$];
  logic        gaps_on = 1'b0;
  logic        throttle = 1'b0;
  logic        capture = 1'b0;
  int          checks = 0;
  int          errors = 0;

  alu_core_top dut0 (.*);

  always #20 clk = ~clk;

  // Taps 16,14,13,11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[14:0],
                    lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [4:0] rand_reg(input int n);
    logic [4:0] r;
    r = 5'(rand_bits(n));
    return (r == 0) ? 5'd1 : r;
  endfunction

  // Expected {illegal, zero, value} for one instruction word
  function automatic logic [33:0] ref_result(input logic [31:0] w, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [31:0] imm;
    logic [31:0] v;
    logic        z;
    imm = {{20{w[31]}}, w[31:20]};
    if (w[6:0] == `EXEC_OPC_LUI) return {2'b00, w[31:12], 12'b0};
    if (w[6:0] == `EXEC_OPC_OP_IMM) begin
      z = 1'b0;
      case (w[14:12])
        3'b000: begin
          v = a + imm;
          z = (v == 0);
        end
        3'b010: v = ($signed(a) < $signed(imm)) ? 1 : 0;
        3'b011: v = (a < imm) ? 1 : 0;
        3'b100: v = a ^ imm;
        3'b110: v = a | imm;
        3'b111: v = a & imm;
        3'b001: begin
          if (w[31:25] != 0) return {1'b1, 33'b0};
          v = a << w[24:20];
        end
        default: begin
          if (w[31:25] == 7'h00) v = a >> w[24:20];
          else if (w[31:25] == 7'h20) v = $signed(a) >>> w[24:20];
          else return {1'b1, 33'b0};
        end
      endcase
      return {1'b0, z, v};
    end
    if (w[6:0] == `EXEC_OPC_OP) begin
      z = 1'b0;
      if (w[31:25] == 7'h20 && w[14:12] == 3'b000) begin
        v = a - b;
        z = (v == 0);
      end else if (w[31:25] == 7'h20 && w[14:12] == 3'b101) begin
        v = $signed(a) >>> b[4:0];
      end else if (w[31:25] != 7'h00) begin
        return {1'b1, 33'b0};
      end else begin
        case (w[14:12])
          3'b000: begin
            v = a + b;
            z = (v == 0);
          end
          3'b001: v = a << b[4:0];
          3'b010: v = ($signed(a) < $signed(b)) ? 1 : 0;
          3'b011: v = (a < b) ? 1 : 0;
          3'b100: v = a ^ b;
          3'b101: v = a >> b[4:0];
          3'b110: v = a | b;
          default: v = a & b;
        endcase
      end
      return {1'b0, z, v};
    end
    return {1'b1, 33'b0};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `EXEC_OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, `EXEC_OPC_OP_IMM};
  endfunction

  function automatic logic [31:0] rand_r_op(input logic [4:0] rd, input int n);
    logic [2:0] f3;
    logic [6:0] f7;
    f3 = 3'(rand_bits(3));
    f7 = ((f3 == 3'b000 || f3 == 3'b101) && rand_bits(1)) ? 7'h20 : 7'h00;
    return enc_r(f7, rand_reg(n), rand_reg(n), f3, rd);
  endfunction

  function automatic logic [31:0] rand_i_op(input logic [4:0] rd, input int n);
    logic [2:0]  f3;
    logic [11:0] imm;
    f3 = 3'(rand_bits(3));
    imm = 12'(rand_bits(12));
    if (f3 == 3'b001) imm[11:5] = 7'h00;
    if (f3 == 3'b101) imm[11:5] = rand_bits(1) ? 7'h20 : 7'h00;
    return enc_i(imm, rand_reg(n), f3, rd);
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  task automatic fail_timeout(input string msg);
    $display("Timeout: %s did not happen in time", msg);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic send_word(input logic [31:0] w);
    int   idle;
    int   waited;
    logic gap;
    idle = 0;
    waited = 0;
    gap = gaps_on && rand_bits(1);
    @(negedge clk);
    while (gap && idle < 6) begin
      inst_valid = 1'b0;
      idle++;
      #1;
      gap = rand_bits(1);
      @(negedge clk);
    end
    inst = w;
    inst_valid = 1'b1;
    #5;
    while (!inst_ready) begin
      waited++;
      if (waited > 200) fail_timeout("instruction accept");
      @(negedge clk);
      #5;
    end
    exp_q.push_back(w);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(negedge clk);
    inst_valid = 1'b0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > 500) fail_timeout("retire of all instructions");
      @(negedge clk);
      #6;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("Test %s finished with %0d errors", name, errors - errs_before);
  endtask

  always @(negedge clk) begin
    retire_ready = throttle ? 1'(rand_bits(1)) : 1'b1;
  end

  // Compares each retire against the reference in program order
  always begin
    logic [31:0] w;
    logic [33:0] res;
    @(negedge clk);
    #5;
    if (!rst && retire_valid && retire_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Error: a retire happened with no instruction outstanding");
      end else begin
        w = exp_q.pop_front();
        res = ref_result(w, model[w[19:15]], model[w[24:20]]);
        check_val(32'(retire.rd), 32'(w[11:7]), "retire rd");
        check_val(32'(retire.illegal), 32'(res[33]), "retire illegal");
        if (!res[33]) begin
          check_val(retire.value, res[31:0], "retire value");
          check_val(32'(retire.zero), 32'(res[32]), "retire zero");
          if (w[11:7] != 0) model[w[11:7]] = res[31:0];
        end
        if (capture) cap_q.push_back(retire.value);
      end
    end
  end

  initial begin
    logic [31:0] prog [$];
    logic [31:0] full_q [$];
    logic [4:0]  prev;
    int          e0;
    for (int i = 0; i < 32; i++) model[i] = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;

    e0 = errors;
    #5;
    check_val(32'(retire_valid), 0, "retire_valid after reset");
    check_val(32'(inst_ready), 1, "inst_ready after reset");
    send_word(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
    drain();
    report_test("reset_add", e0);

    e0 = errors;
    for (int r = 1; r < 16; r++) send_word({20'(rand_bits(20)), r[4:0], `EXEC_OPC_LUI});
    for (int i = 0; i < 30; i++) send_word(rand_i_op(rand_reg(4), 4));
    send_word(enc_i(12'd0, 5'd0, 3'b000, 5'd2));
    drain();
    report_test("lui_itype", e0);

    e0 = errors;
    for (int i = 0; i < 40; i++) send_word(rand_r_op(rand_reg(4), 4));
    drain();
    report_test("rtype", e0);

    e0 = errors;
    prev = 5'd1;
    for (int i = 0; i < 20; i++) begin
      logic [4:0] rd;
      rd = rand_reg(4);
      send_word(rand_bits(1) ? enc_r(7'h00, prev, prev, 3'b000, rd)
                             : enc_i(12'(rand_bits(12)), prev, 3'b100, rd));
      prev = rd;
    end
    drain();
    report_test("dependent_chain", e0);

    // Same self-contained program at full rate and then throttled
    e0 = errors;
    for (int r = 1; r < 8; r++) prog.push_back({20'(rand_bits(20)), r[4:0], `EXEC_OPC_LUI});
    for (int i = 0; i < 24; i++) begin
      prog.push_back(rand_bits(1) ? rand_r_op(rand_reg(3), 3) : rand_i_op(rand_reg(3), 3));
    end
    capture = 1'b1;
    foreach (prog[i]) send_word(prog[i]);
    drain();
    report_test("full_rate", e0);
    full_q = cap_q;
    cap_q.delete();
    e0 = errors;
    gaps_on = 1'b1;
    throttle = 1'b1;
    foreach (prog[i]) send_word(prog[i]);
    drain();
    capture = 1'b0;
    gaps_on = 1'b0;
    throttle = 1'b0;
    check_val(cap_q.size(), full_q.size(), "retire count under back-pressure");
    foreach (full_q[i]) begin
      if (i < cap_q.size()) check_val(cap_q[i], full_q[i], "retire sequence");
    end
    report_test("back_pressure", e0);

    e0 = errors;
    send_word(enc_i(12'd5, 5'd1, 3'b000, 5'd0));
    send_word({20'habcde, 5'd4, 7'b1111111});
    send_word(enc_r(7'h00, 5'd0, 5'd0, 3'b110, 5'd3));
    send_word(enc_r(7'h00, 5'd0, 5'd4, 3'b110, 5'd5));
    drain();
    report_test("x0_illegal", e0);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- dv/alu_core_asserts.sv
`timescale 1ns/100ps

module alu_core_asserts (
  input logic              clk,
  input logic              rst,
  input logic              retire_valid,
  input logic              retire_ready,
  input exec_pkg::retire_t retire,
  input exec_pkg::wb_t     wb
);

  a_retire_stable: assert property (@(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else $error("retire payload changed while stalled");

  a_wb_needs_retire: assert property (@(posedge clk) disable iff (rst)
    wb.en |-> retire_valid && retire_ready)
    else $error("write-back without a retire transfer");

  a_wb_addr_nonzero: assert property (@(posedge clk) disable iff (rst)
    wb.en |-> wb.addr != '0)
    else $error("write-back to x0");

  a_reset_idle: assert property (@(posedge clk) rst |=> !retire_valid)
    else $error("retire_valid high after reset");

endmodule

bind exec_unit alu_core_asserts u_asserts (
  .clk          (clk),
  .rst          (rst),
  .retire_valid (retire_valid),
  .retire_ready (retire_ready),
  .retire       (retire),
  .wb           (wb)
);

//--- source/alu_core_top.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module alu_core_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inst_valid,
  output logic                 inst_ready,
  input  exec_pkg::inst_word_u inst,
  output logic                 retire_valid,
  input  logic                 retire_ready,
  output exec_pkg::retire_t    retire
);

  import exec_pkg::*;

  logic [`EXEC_REG_AW-1:0] rs1_addr;
  logic [`EXEC_REG_AW-1:0] rs2_addr;
  logic [`EXEC_XLEN-1:0]   rs1_data;
  logic [`EXEC_XLEN-1:0]   rs2_data;
  logic                    issue_valid;
  logic                    issue_ready;
  issue_t                  issue;
  exec_status_t            status;
  wb_t                     wb;

  inst_decoder u_decoder (
    .inst_valid  (inst_valid),
    .inst_ready  (inst_ready),
    .inst        (inst),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .status      (status),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .issue       (issue)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb       (wb)
  );

  exec_unit u_exec_unit (
    .clk          (clk),
    .rst          (rst),
    .issue_valid  (issue_valid),
    .issue_ready  (issue_ready),
    .issue        (issue),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire),
    .status       (status),
    .wb           (wb)
  );

endmodule

//--- source/exec_unit.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module exec_unit (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   issue_valid,
  output logic                   issue_ready,
  input  exec_pkg::issue_t       issue,
  output logic                   retire_valid,
  input  logic                   retire_ready,
  output exec_pkg::retire_t      retire,
  output exec_pkg::exec_status_t status,
  output exec_pkg::wb_t          wb
);

  import exec_pkg::*;

  logic                     held_valid;
  issue_t                   held;
  logic [`EXEC_XLEN:0]      diff;
  logic [`EXEC_SHAMT_W-1:0] shamt;
  logic [`EXEC_XLEN-1:0]    alu_value;
  logic                     alu_zero;
  logic                     retire_fire;

  // Free slot, or the held item leaves this cycle
  assign issue_ready = !held_valid || retire_ready;
  assign retire_fire = held_valid && retire_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      held_valid <= 1'b0;
    end else if (issue_ready) begin
      held_valid <= issue_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid && issue_ready) begin
      held <= issue;
    end
  end

  always_comb begin
    diff  = {1'b0, held.src1} - {1'b0, held.src2};
    shamt = held.src2[`EXEC_SHAMT_W-1:0];
    case (held.op)
      OP_PASS2: alu_value = held.src2;
      OP_ADD:   alu_value = held.src1 + held.src2;
      OP_SUB:   alu_value = diff[`EXEC_XLEN-1:0];
      OP_AND:   alu_value = held.src1 & held.src2;
      OP_OR:    alu_value = held.src1 | held.src2;
      OP_XOR:   alu_value = held.src1 ^ held.src2;
      OP_SLL:   alu_value = held.src1 << shamt;
      OP_SRL:   alu_value = held.src1 >> shamt;
      OP_SRA:   alu_value = $signed(held.src1) >>> shamt;
      OP_SLT: begin
        alu_value = {{(`EXEC_XLEN-1){1'b0}}, $signed(held.src1) < $signed(held.src2)};
      end
      // Borrow out of the 33-bit subtract
      OP_SLTU:  alu_value = {{(`EXEC_XLEN-1){1'b0}}, diff[`EXEC_XLEN]};
      default:  alu_value = '0;
    endcase
    alu_zero = ((held.op == OP_ADD) || (held.op == OP_SUB)) && (alu_value == '0);
  end

  assign retire_valid = held_valid;

  always_comb begin
    retire.rd      = held.rd;
    retire.value   = alu_value;
    retire.zero    = alu_zero;
    retire.illegal = held.illegal;
  end

  // Status mirrors the held entry and reads zero when empty
  always_comb begin
    status.busy       = held_valid;
    status.writes_reg = held_valid && held.write_en;
    status.rd         = held_valid ? held.rd : '0;
  end

  always_comb begin
    wb.en   = retire_fire && held.write_en && (held.rd != '0);
    wb.addr = held.rd;
    wb.data = alu_value;
  end

endmodule

//--- source/inst_decoder.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module inst_decoder (
  input  logic                    inst_valid,
  output logic                    inst_ready,
  input  exec_pkg::inst_word_u    inst,
  output logic [`EXEC_REG_AW-1:0] rs1_addr,
  output logic [`EXEC_REG_AW-1:0] rs2_addr,
  input  logic [`EXEC_XLEN-1:0]   rs1_data,
  input  logic [`EXEC_XLEN-1:0]   rs2_data,
  input  exec_pkg::exec_status_t  status,
  output logic                    issue_valid,
  input  logic                    issue_ready,
  output exec_pkg::issue_t        issue
);

  import exec_pkg::*;

  alu_op_e               op;
  logic [`EXEC_XLEN-1:0] src2;
  logic                  uses_rs1;
  logic                  uses_rs2;
  logic                  legal;
  logic                  hazard;

  assign rs1_addr = inst.r_fmt.rs1;
  assign rs2_addr = inst.r_fmt.rs2;

  always_comb begin
    op       = OP_ADD;
    src2     = rs2_data;
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    legal    = 1'b1;
    case (inst.r_fmt.opcode)
      `EXEC_OPC_OP: begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case ({inst.r_fmt.funct7, inst.r_fmt.funct3})
          {`EXEC_F7_BASE, 3'b000}: op = OP_ADD;
          {`EXEC_F7_ALT,  3'b000}: op = OP_SUB;
          {`EXEC_F7_BASE, 3'b001}: op = OP_SLL;
          {`EXEC_F7_BASE, 3'b010}: op = OP_SLT;
          {`EXEC_F7_BASE, 3'b011}: op = OP_SLTU;
          {`EXEC_F7_BASE, 3'b100}: op = OP_XOR;
          {`EXEC_F7_BASE, 3'b101}: op = OP_SRL;
          {`EXEC_F7_ALT,  3'b101}: op = OP_SRA;
          {`EXEC_F7_BASE, 3'b110}: op = OP_OR;
          {`EXEC_F7_BASE, 3'b111}: op = OP_AND;
          default:                 legal = 1'b0;
        endcase
      end
      `EXEC_OPC_OP_IMM: begin
        uses_rs1 = 1'b1;
        src2 = {{(`EXEC_XLEN-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
        case (inst.i_fmt.funct3)
          3'b000: op = OP_ADD;
          3'b010: op = OP_SLT;
          3'b011: op = OP_SLTU;
          3'b100: op = OP_XOR;
          3'b110: op = OP_OR;
          3'b111: op = OP_AND;
          default: begin
            // Shift immediates take shamt from the rs2 slot
            src2 = {{(`EXEC_XLEN-`EXEC_SHAMT_W){1'b0}}, inst.r_fmt.rs2};
            if (inst.i_fmt.funct3 == 3'b001 && inst.r_fmt.funct7 == `EXEC_F7_BASE) begin
              op = OP_SLL;
            end else if (inst.r_fmt.funct7 == `EXEC_F7_BASE) begin
              op = OP_SRL;
            end else if (inst.i_fmt.funct3 == 3'b101 && inst.r_fmt.funct7 == `EXEC_F7_ALT) begin
              op = OP_SRA;
            end else begin
              legal = 1'b0;
            end
          end
        endcase
      end
      `EXEC_OPC_LUI: begin
        op   = OP_PASS2;
        src2 = {inst.u_fmt.imm20, 12'b0};
      end
      default: legal = 1'b0;
    endcase
  end

  // RAW against the single in-flight producer
  assign hazard = status.busy && status.writes_reg && (status.rd != '0) &&
                  ((uses_rs1 && (status.rd == inst.r_fmt.rs1)) ||
                   (uses_rs2 && (status.rd == inst.r_fmt.rs2)));

  assign issue_valid = inst_valid && !hazard;
  assign inst_ready  = issue_ready && !hazard;

  always_comb begin
    issue.op       = op;
    issue.src1     = rs1_data;
    issue.src2     = src2;
    issue.rd       = inst.r_fmt.rd;
    issue.write_en = legal;
    issue.illegal  = !legal;
  end

endmodule

//--- source/reg_file.sv
`timescale 1ns/100ps
`include "exec_macros.svh"

module reg_file (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [`EXEC_REG_AW-1:0] rs1_addr,
  input  logic [`EXEC_REG_AW-1:0] rs2_addr,
  output logic [`EXEC_XLEN-1:0]   rs1_data,
  output logic [`EXEC_XLEN-1:0]   rs2_data,
  input  exec_pkg::wb_t           wb
);

  logic [`EXEC_XLEN-1:0] regs [`EXEC_REG_COUNT];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXEC_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.en && (wb.addr != '0)) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // x0 is hardwired to zero
  always_comb begin
    rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
  end

endmodule

//--- source/exec_pkg.sv
`include "exec_macros.svh"

package exec_pkg;

  // Pass-src2 sits at key 0
  typedef enum logic [4:0] {
    OP_ADD   = 5'd1,
    OP_SUB   = 5'd2,
    OP_AND   = 5'd3,
    OP_OR    = 5'd5,
    OP_XOR   = 5'd4,
    OP_SLL   = 5'd6,
    OP_SRL   = 5'd7,
    OP_SRA   = 5'd9,
    OP_SLT   = 5'd10,
    OP_SLTU  = 5'd11,
    OP_PASS2 = 5'd0
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [19:0] imm20;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // One instruction word seen through each format
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
  } inst_word_u;

  typedef struct packed {
    alu_op_e                 op;
    logic [`EXEC_XLEN-1:0]   src1;
    logic [`EXEC_XLEN-1:0]   src2;
    logic [`EXEC_REG_AW-1:0] rd;
    logic                    write_en;
    logic                    illegal;
  } issue_t;

  typedef struct packed {
    logic [`EXEC_REG_AW-1:0] rd;
    logic [`EXEC_XLEN-1:0]   value;
    logic                    zero;
    logic                    illegal;
  } retire_t;

  typedef struct packed {
    logic                    busy;
    logic                    writes_reg;
    logic [`EXEC_REG_AW-1:0] rd;
  } exec_status_t;

  typedef struct packed {
    logic                    en;
    logic [`EXEC_REG_AW-1:0] addr;
    logic [`EXEC_XLEN-1:0]   data;
  } wb_t;

endpackage

//--- include/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Datapath sizing
`define EXEC_XLEN      32
`define EXEC_REG_AW    5
`define EXEC_REG_COUNT 32

// Major opcodes handled by the decoder
`define EXEC_OPC_OP     7'b0110011
`define EXEC_OPC_OP_IMM 7'b0010011
`define EXEC_OPC_LUI    7'b0110111

// funct7 patterns for base and alternate ops
`define EXEC_F7_BASE 7'b0000000
`define EXEC_F7_ALT  7'b0100000

// Width of the shift amount field
`define EXEC_SHAMT_W 5

`endif
